//--- fetch_unit.f
+incdir+source
source/fetch_pkg.sv
source/itim.sv
source/branch_predictor.sv
source/fetch_stage.sv
source/fetch_unit.sv
sim/fetch_unit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f fetch_unit.f --top-module fetch_unit_tb -o fetch_sim

# The simulation status is taken from the log, so a $fatal exit must not stop the script here
./obj_dir/fetch_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
  exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
  echo "simulation ended without a result line"
  exit 1
fi

//--- sim/fetch_golden.txt
// Record: kind a b c d. Kind 1 load: addr word1 word0 0. Kind 2 event: delivered type addr target
// Kind 3 expect: pc predicted 0 0. Kind 0 ends. Types 1 trap 2 mret 3 mispredict 4 fence 5 trap+mispredict 6 taken resolve 7 not-taken resolve
1 000 B0000004 A0000000 0
1 008 B000000C A0000008 0
1 010 B0000014 A0000010 0
1 018 B000001C A0000018 0
1 100 B0000104 A0000100 0
1 108 B000010C A0000108 0
1 200 B0000204 A0000200 0
1 208 B000020C A0000208 0
1 210 B0000214 A0000210 0
1 300 B0000304 A0000300 0
1 308 B000030C A0000308 0
1 400 B0000404 A0000400 0
1 408 B000040C A0000408 0
2 3 5 100 200
2 5 2 018 0
2 6 3 200 0
2 7 4 300 0
2 9 6 208 400
2 9 6 208 400
2 9 3 200 0
2 d 7 208 0
2 d 7 208 0
2 d 3 200 0
3 000 0 0 0
3 008 0 0 0
3 010 0 0 0
3 100 0 0 0
3 108 0 0 0
3 018 0 0 0
3 200 0 0 0
3 300 0 0 0
3 308 0 0 0
3 200 0 0 0
3 208 0 0 0
3 400 1 0 0
3 408 0 0 0
3 200 0 0 0
3 208 0 0 0
3 210 0 0 0
0 0 0 0 0

//--- sim/fetch_unit_tb.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_unit_tb;

  import fetch_pkg::*;

  localparam int record_w = 5;
  localparam int max_records = 64;

  logic clock;
  logic reset;
  logic trap;
  fetch_addr_t trap_vector;
  logic mret;
  fetch_addr_t return_pc;
  logic mispredict;
  fetch_addr_t mispredict_pc;
  logic fence;
  fetch_addr_t fence_pc;
  logic decode_stall;
  logic fetch_valid;
  fetch_addr_t fetch_pc;
  fetch_bundle_t fetch_bundle;
  logic fetch_predicted;
  logic load_valid;
  fetch_addr_t load_addr;
  fetch_bundle_t load_data;
  logic resolve_valid;
  fetch_addr_t resolve_pc;
  logic resolve_taken;
  fetch_addr_t resolve_target;

  logic [31:0] golden_words [record_w*max_records];
  fetch_bundle_t image [`ITIM_DEPTH];
  fetch_addr_t load_addrs [$];
  int unsigned event_counts [$];
  int unsigned event_types [$];
  fetch_addr_t event_addrs [$];
  fetch_addr_t event_targets [$];
  fetch_addr_t expect_pcs [$];
  logic expect_flags [$];
  int unsigned rng_state;
  int unsigned burst_left;
  int unsigned delivered;
  int unsigned next_event;
  int unsigned cycles;
  int unsigned limit;
  int word_index;
  logic held_valid;
  fetch_addr_t held_pc;
  fetch_bundle_t held_bundle;

  initial clock = 1'b0;
  always #2 clock = ~clock;

  fetch_unit fetch_unit_inst (
    .clock(clock), .reset(reset),
    .trap(trap), .trap_vector(trap_vector), .mret(mret), .return_pc(return_pc),
    .mispredict(mispredict), .mispredict_pc(mispredict_pc), .fence(fence), .fence_pc(fence_pc),
    .decode_stall(decode_stall), .fetch_valid(fetch_valid), .fetch_pc(fetch_pc),
    .fetch_bundle(fetch_bundle), .fetch_predicted(fetch_predicted),
    .load_valid(load_valid), .load_addr(load_addr), .load_data(load_data),
    .resolve_valid(resolve_valid), .resolve_pc(resolve_pc), .resolve_taken(resolve_taken),
    .resolve_target(resolve_target)
  );

  function automatic int unsigned next_random(input int unsigned state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic stop_run();
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic compare_pc(input fetch_addr_t got, input fetch_addr_t expected, input string what);
    if (got !== expected) begin
      $display("mismatch at time %0t: %s is %h, expected %h", $time, what, got, expected);
      stop_run();
    end
  endtask

  task automatic compare_bundle(input fetch_bundle_t got, input fetch_bundle_t expected,
                                input string what);
    if (got !== expected) begin
      $display("mismatch at time %0t: %s is %h, expected %h", $time, what, got, expected);
      stop_run();
    end
  endtask

  task automatic compare_flag(input logic got, input logic expected, input string what);
    if (got !== expected) begin
      $display("mismatch at time %0t: %s is %b, expected %b", $time, what, got, expected);
      stop_run();
    end
  endtask

  task automatic clear_events();
    trap = 1'b0;
    mret = 1'b0;
    mispredict = 1'b0;
    fence = 1'b0;
    resolve_valid = 1'b0;
  endtask

  task automatic raise_event(input int unsigned kind, input fetch_addr_t addr,
                             input fetch_addr_t target);
    case (kind)
      1: begin
        trap = 1'b1;
        trap_vector = addr;
      end
      2: begin
        mret = 1'b1;
        return_pc = addr;
      end
      3: begin
        mispredict = 1'b1;
        mispredict_pc = addr;
      end
      4: begin
        fence = 1'b1;
        fence_pc = addr;
      end
      // The trap has to win over the mispredict raised with it
      5: begin
        trap = 1'b1;
        trap_vector = addr;
        mispredict = 1'b1;
        mispredict_pc = target;
      end
      6, 7: begin
        resolve_valid = 1'b1;
        resolve_taken = (kind == 6);
        resolve_pc = addr;
        resolve_target = target;
      end
      default: begin
        $display("golden file holds an unknown event type %0d", kind);
        stop_run();
      end
    endcase
  endtask

  initial begin
    reset = 1'b0;
    clear_events();
    {trap_vector, return_pc, mispredict_pc, fence_pc} = '0;
    {resolve_pc, resolve_target, resolve_taken} = '0;
    decode_stall = 1'b0;
    load_valid = 1'b0;
    load_addr = '0;
    load_data = '0;
    rng_state = 82156;
    {burst_left, delivered, next_event, cycles} = '0;
    held_valid = 1'b0;

    $readmemh("sim/fetch_golden.txt", golden_words);
    word_index = 0;
    while (word_index < record_w*max_records && golden_words[word_index] != 0) begin
      case (golden_words[word_index])
        1: begin
          load_addrs.push_back(golden_words[word_index+1]);
          image[(golden_words[word_index+1] >> 3) % `ITIM_DEPTH] =
            {golden_words[word_index+2], golden_words[word_index+3]};
        end
        2: begin
          event_counts.push_back(golden_words[word_index+1]);
          event_types.push_back(golden_words[word_index+2]);
          event_addrs.push_back(golden_words[word_index+3]);
          event_targets.push_back(golden_words[word_index+4]);
        end
        3: begin
          expect_pcs.push_back(golden_words[word_index+1]);
          expect_flags.push_back(golden_words[word_index+2][0]);
        end
        default: begin
          $display("golden file holds an unknown record kind at word %0d", word_index);
          stop_run();
        end
      endcase
      word_index += record_w;
    end
    if (expect_pcs.size() == 0) begin
      $display("golden file holds no expected program counters");
      stop_run();
    end

    // The image is written between two reset pulses so that fetch restarts on loaded memory
    repeat (3) @(posedge clock);
    #0.5;
    reset = 1'b1;
    foreach (load_addrs[i]) begin
      load_valid = 1'b1;
      load_addr = load_addrs[i];
      load_data = image[(load_addrs[i] >> 3) % `ITIM_DEPTH];
      @(posedge clock);
      #0.5;
    end
    load_valid = 1'b0;
    reset = 1'b0;
    repeat (3) @(posedge clock);
    #0.5;
    reset = 1'b1;

    limit = expect_pcs.size() * (`ITIM_MISS_CYCLES + 20);
    while (delivered < expect_pcs.size()) begin
      @(negedge clock);
      cycles++;
      if (cycles > limit) begin
        $display("timeout: %0d of %0d bundles delivered in %0d cycles",
                 delivered, expect_pcs.size(), cycles);
        stop_run();
      end
      if (held_valid && fetch_valid) begin
        compare_pc(fetch_pc, held_pc, "pc under stall");
        compare_bundle(fetch_bundle, held_bundle, "bundle under stall");
      end
      held_valid = fetch_valid && decode_stall;
      held_pc = fetch_pc;
      held_bundle = fetch_bundle;
      if (fetch_valid && !decode_stall) begin
        compare_pc(fetch_pc, expect_pcs[delivered], "delivered pc");
        compare_bundle(fetch_bundle, image[(expect_pcs[delivered] >> 3) % `ITIM_DEPTH],
                       "delivered bundle");
        compare_flag(fetch_predicted, expect_flags[delivered], "fetch_predicted");
        delivered++;
      end

      @(posedge clock);
      #0.5;
      clear_events();
      if (next_event < event_types.size() && event_counts[next_event] <= delivered) begin
        // Decode holds still while an event is raised so the bundle count stays exact
        raise_event(event_types[next_event], event_addrs[next_event], event_targets[next_event]);
        decode_stall = 1'b1;
        next_event++;
      end else if (burst_left > 0) begin
        decode_stall = 1'b1;
        burst_left--;
      end else begin
        rng_state = next_random(rng_state);
        decode_stall = (rng_state[17:16] == 2'd0);
        burst_left = decode_stall ? rng_state[19:18] : 0;
      end
    end

    if (next_event == event_types.size()) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      $display("%0d events were never raised", event_types.size() - next_event);
      stop_run();
    end
  end

endmodule

//--- source/branch_predictor.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module branch_predictor (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   lookup_valid,
  input  fetch_pkg::fetch_addr_t lookup_pc,
  output logic                   pred_taken,
  output fetch_pkg::fetch_addr_t pred_target,
  input  logic                   resolve_valid,
  input  fetch_pkg::fetch_addr_t resolve_pc,
  input  logic                   resolve_taken,
  input  fetch_pkg::fetch_addr_t resolve_target,
  input  logic                   clear
);

  import fetch_pkg::*;

  // Bits [2:0] select a byte inside the bundle and take no part in the index
  localparam int index_w = $clog2(`BP_ENTRIES);
  localparam int tag_lsb = 3 + index_w;
  localparam int tag_w = `FETCH_ADDR_W - tag_lsb;

  logic entry_valid_q [`BP_ENTRIES];
  logic [1:0] counter_q [`BP_ENTRIES];
  logic [tag_w-1:0] tag_mem [`BP_ENTRIES];
  fetch_addr_t target_mem [`BP_ENTRIES];

  logic [index_w-1:0] lookup_index;
  logic [tag_w-1:0] lookup_tag;
  logic lookup_hit;
  logic [index_w-1:0] resolve_index;
  logic [tag_w-1:0] resolve_tag;
  logic resolve_hit;

  // Saturating 2-bit counter step
  function automatic logic [1:0] next_counter(input logic [1:0] count, input logic taken);
    logic [1:0] result;
    result = count;
    if (taken && count != 2'd3) begin
      result = count + 2'd1;
    end else if (!taken && count != 2'd0) begin
      result = count - 2'd1;
    end
    return result;
  endfunction

  assign lookup_index = lookup_pc[3 +: index_w];
  assign lookup_tag = lookup_pc[tag_lsb +: tag_w];
  assign lookup_hit = entry_valid_q[lookup_index] && (tag_mem[lookup_index] == lookup_tag);

  assign resolve_index = resolve_pc[3 +: index_w];
  assign resolve_tag = resolve_pc[tag_lsb +: tag_w];
  assign resolve_hit = entry_valid_q[resolve_index] && (tag_mem[resolve_index] == resolve_tag);

  // Tags and targets are written on every taken resolve
  always_ff @(posedge clock) begin
    if (resolve_valid && resolve_taken) begin
      tag_mem[resolve_index] <= resolve_tag;
      target_mem[resolve_index] <= resolve_target;
    end
    if (lookup_valid) begin
      pred_target <= target_mem[lookup_index];
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      pred_taken <= 1'b0;
      for (int i = 0; i < `BP_ENTRIES; i++) begin
        entry_valid_q[i] <= 1'b0;
        counter_q[i] <= 2'd1;
      end
    end else begin
      // The prediction holds until the next lookup, or until a stronger redirect drops it
      if (clear) begin
        pred_taken <= 1'b0;
      end else if (lookup_valid) begin
        pred_taken <= lookup_hit && counter_q[lookup_index][1];
      end

      if (resolve_valid) begin
        if (resolve_hit) begin
          counter_q[resolve_index] <= next_counter(counter_q[resolve_index], resolve_taken);
        end else if (resolve_taken) begin
          // A new entry starts from the reset value and counts the taken resolve
          entry_valid_q[resolve_index] <= 1'b1;
          counter_q[resolve_index] <= next_counter(2'd1, 1'b1);
        end
      end
    end
  end

endmodule

//--- source/fetch_defs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// A bundle holds two 32-bit instructions
`define FETCH_ADDR_W 32
`define FETCH_BUNDLE_W 64
`define FETCH_RESET_PC 32'h0000_0000

// Instruction memory depth is counted in bundles
`define ITIM_DEPTH 256
`define ITIM_MISS_CYCLES 3

`define BP_ENTRIES 16

`endif

//--- source/fetch_pkg.sv
`include "fetch_defs.svh"

package fetch_pkg;

  typedef logic [`FETCH_ADDR_W-1:0] fetch_addr_t;

  // Word 0 sits at the bundle address, word 1 four bytes above it
  typedef logic [`FETCH_BUNDLE_W/2-1:0] fetch_word_t;
  typedef fetch_word_t [1:0] fetch_bundle_t;

  // Idle only follows reset, jump waits out a wrong-path response
  typedef enum logic [1:0] {
    fetch_idle,
    fetch_busy,
    fetch_jump
  } fetch_state_e;

  // Listed from the highest to the lowest priority
  typedef enum logic [2:0] {
    cause_none,
    cause_trap,
    cause_mret,
    cause_mispredict,
    cause_fence,
    cause_predict
  } redirect_cause_e;

endpackage

//--- source/fetch_stage.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_stage (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     trap,
  input  fetch_pkg::fetch_addr_t   trap_vector,
  input  logic                     mret,
  input  fetch_pkg::fetch_addr_t   return_pc,
  input  logic                     mispredict,
  input  fetch_pkg::fetch_addr_t   mispredict_pc,
  input  logic                     fence,
  input  fetch_pkg::fetch_addr_t   fence_pc,
  input  logic                     pred_taken,
  input  fetch_pkg::fetch_addr_t   pred_target,
  output logic                     lookup_valid,
  output fetch_pkg::fetch_addr_t   lookup_pc,
  output logic                     bp_clear,
  output logic                     mem_valid,
  output fetch_pkg::fetch_addr_t   mem_addr,
  output logic                     mem_fence,
  output logic                     mem_spec,
  input  logic                     mem_ready,
  input  fetch_pkg::fetch_bundle_t mem_rdata,
  input  logic                     decode_stall,
  output logic                     fetch_valid,
  output fetch_pkg::fetch_addr_t   fetch_pc,
  output fetch_pkg::fetch_bundle_t fetch_bundle,
  output logic                     fetch_predicted
);

  import fetch_pkg::*;

  fetch_state_e state_q;
  fetch_state_e state_next;
  redirect_cause_e cause;
  fetch_addr_t target;
  fetch_addr_t jump_pc_q;
  fetch_addr_t issue_addr;
  logic jump_fence_q;
  logic req_pred_q;
  logic external;
  logic slot_free;
  logic deliver;
  logic issue;
  logic issue_fence;
  logic issue_spec;
  logic issue_pred;

  always_comb begin
    cause = cause_none;
    target = mem_addr;
    if (trap) begin
      cause = cause_trap;
      target = trap_vector;
    end else if (mret) begin
      cause = cause_mret;
      target = return_pc;
    end else if (mispredict) begin
      cause = cause_mispredict;
      target = mispredict_pc;
    end else if (fence) begin
      cause = cause_fence;
      target = fence_pc;
    end else if (state_q == fetch_busy && mem_ready && pred_taken) begin
      cause = cause_predict;
      target = pred_target;
    end
  end

  assign external = (cause != cause_none) && (cause != cause_predict);
  assign slot_free = !fetch_valid || !decode_stall;
  assign deliver = (state_q == fetch_busy) && mem_ready && !external && slot_free;

  // A response that finds the output held is dropped and the same bundle is fetched again
  always_comb begin
    state_next = state_q;
    issue = 1'b0;
    issue_addr = mem_addr;
    issue_fence = 1'b0;
    issue_spec = mem_spec;
    issue_pred = req_pred_q;
    case (state_q)
      fetch_idle: begin
        state_next = fetch_busy;
        issue = 1'b1;
        issue_addr = external ? target : `FETCH_RESET_PC;
        issue_fence = (cause == cause_fence);
        issue_spec = external;
        issue_pred = 1'b0;
      end
      fetch_busy: begin
        if (mem_ready) begin
          issue = 1'b1;
          if (external) begin
            issue_addr = target;
            issue_fence = (cause == cause_fence);
            issue_spec = 1'b1;
            issue_pred = 1'b0;
          end else if (slot_free) begin
            issue_addr = (cause == cause_predict) ? target :
                         mem_addr + fetch_addr_t'(`FETCH_BUNDLE_W / 8);
            issue_spec = (cause == cause_predict);
            issue_pred = (cause == cause_predict);
          end
        end else if (external) begin
          state_next = fetch_jump;
        end
      end
      fetch_jump: begin
        if (mem_ready) begin
          state_next = fetch_busy;
          issue = 1'b1;
          issue_addr = external ? target : jump_pc_q;
          issue_fence = external ? (cause == cause_fence) : jump_fence_q;
          issue_spec = 1'b1;
          issue_pred = 1'b0;
        end
      end
      default: state_next = fetch_idle;
    endcase
  end

  always_ff @(posedge clock) begin
    if (issue) begin
      mem_addr <= issue_addr;
    end
    if (external) begin
      jump_pc_q <= target;
    end
    if (deliver) begin
      fetch_pc <= mem_addr;
      fetch_bundle <= mem_rdata;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state_q <= fetch_idle;
      mem_valid <= 1'b0;
      mem_fence <= 1'b0;
      mem_spec <= 1'b0;
      req_pred_q <= 1'b0;
      jump_fence_q <= 1'b0;
      fetch_valid <= 1'b0;
      fetch_predicted <= 1'b0;
    end else begin
      state_q <= state_next;
      mem_valid <= issue;
      mem_fence <= issue && issue_fence;
      if (issue) begin
        mem_spec <= issue_spec;
        req_pred_q <= issue_pred;
      end
      if (external) begin
        jump_fence_q <= (cause == cause_fence);
      end
      // The bundle on display is younger than any redirecting instruction
      if (deliver) begin
        fetch_valid <= 1'b1;
        fetch_predicted <= req_pred_q;
      end else if (external || !decode_stall) begin
        fetch_valid <= 1'b0;
      end
    end
  end

  assign lookup_valid = mem_valid;
  assign lookup_pc = mem_addr;
  assign bp_clear = external;

  assert property (@(posedge clock) disable iff (!reset)
    (state_q == fetch_jump) |-> !fetch_valid)
    else $error("bundle presented to decode during a jump");

endmodule

//--- source/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     trap,
  input  fetch_pkg::fetch_addr_t   trap_vector,
  input  logic                     mret,
  input  fetch_pkg::fetch_addr_t   return_pc,
  input  logic                     mispredict,
  input  fetch_pkg::fetch_addr_t   mispredict_pc,
  input  logic                     fence,
  input  fetch_pkg::fetch_addr_t   fence_pc,
  input  logic                     decode_stall,
  output logic                     fetch_valid,
  output fetch_pkg::fetch_addr_t   fetch_pc,
  output fetch_pkg::fetch_bundle_t fetch_bundle,
  output logic                     fetch_predicted,
  input  logic                     load_valid,
  input  fetch_pkg::fetch_addr_t   load_addr,
  input  fetch_pkg::fetch_bundle_t load_data,
  input  logic                     resolve_valid,
  input  fetch_pkg::fetch_addr_t   resolve_pc,
  input  logic                     resolve_taken,
  input  fetch_pkg::fetch_addr_t   resolve_target
);

  import fetch_pkg::*;

  logic mem_valid;
  fetch_addr_t mem_addr;
  logic mem_fence;
  logic mem_ready;
  fetch_bundle_t mem_rdata;
  logic lookup_valid;
  fetch_addr_t lookup_pc;
  logic pred_taken;
  fetch_addr_t pred_target;
  logic bp_clear;

  fetch_stage fetch_stage_inst (
    .clock           (clock),
    .reset           (reset),
    .trap            (trap),
    .trap_vector     (trap_vector),
    .mret            (mret),
    .return_pc       (return_pc),
    .mispredict      (mispredict),
    .mispredict_pc   (mispredict_pc),
    .fence           (fence),
    .fence_pc        (fence_pc),
    .pred_taken      (pred_taken),
    .pred_target     (pred_target),
    .lookup_valid    (lookup_valid),
    .lookup_pc       (lookup_pc),
    .bp_clear        (bp_clear),
    .mem_valid       (mem_valid),
    .mem_addr        (mem_addr),
    .mem_fence       (mem_fence),
    .mem_spec        (),
    .mem_ready       (mem_ready),
    .mem_rdata       (mem_rdata),
    .decode_stall    (decode_stall),
    .fetch_valid     (fetch_valid),
    .fetch_pc        (fetch_pc),
    .fetch_bundle    (fetch_bundle),
    .fetch_predicted (fetch_predicted)
  );

  branch_predictor branch_predictor_inst (
    .clock          (clock),
    .reset          (reset),
    .lookup_valid   (lookup_valid),
    .lookup_pc      (lookup_pc),
    .pred_taken     (pred_taken),
    .pred_target    (pred_target),
    .resolve_valid  (resolve_valid),
    .resolve_pc     (resolve_pc),
    .resolve_taken  (resolve_taken),
    .resolve_target (resolve_target),
    .clear          (bp_clear)
  );

  itim itim_inst (
    .clock      (clock),
    .reset      (reset),
    .mem_valid  (mem_valid),
    .mem_addr   (mem_addr),
    .mem_fence  (mem_fence),
    .mem_ready  (mem_ready),
    .mem_rdata  (mem_rdata),
    .load_valid (load_valid),
    .load_addr  (load_addr),
    .load_data  (load_data)
  );

  // A taken prediction on a delivered bundle sends the very next request to its target
  assert property (@(posedge clock) disable iff (!reset)
    (fetch_stage_inst.cause == cause_predict && (!fetch_valid || !decode_stall))
      |=> (mem_valid && mem_addr == $past(pred_target)))
    else $error("predicted target was not requested");

  // A fence request always pays the full miss latency
  assert property (@(posedge clock) disable iff (!reset)
    (mem_valid && mem_fence) |=> !mem_ready)
    else $error("fence request hit the line buffer");

endmodule

//--- source/itim.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module itim (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     mem_valid,
  input  fetch_pkg::fetch_addr_t   mem_addr,
  input  logic                     mem_fence,
  output logic                     mem_ready,
  output fetch_pkg::fetch_bundle_t mem_rdata,
  input  logic                     load_valid,
  input  fetch_pkg::fetch_addr_t   load_addr,
  input  fetch_pkg::fetch_bundle_t load_data
);

  import fetch_pkg::*;

  localparam int index_w = $clog2(`ITIM_DEPTH);
  localparam int miss_w = $clog2(`ITIM_MISS_CYCLES + 1);

  fetch_bundle_t mem_array [`ITIM_DEPTH];
  fetch_bundle_t rdata_q;
  logic [index_w-1:0] req_index;
  logic [index_w-1:0] load_index;
  logic [index_w-1:0] line_index_q;
  logic line_valid_q;
  logic line_hit;
  logic pending_q;
  logic accept;
  logic [miss_w-1:0] wait_count_q;

  assign req_index = mem_addr[3 +: index_w];
  assign load_index = load_addr[3 +: index_w];
  assign accept = mem_valid && !pending_q;

  // The line buffer covers the buffered bundle and the one after it
  assign line_hit = line_valid_q && !mem_fence &&
                    (req_index == line_index_q || req_index == line_index_q + 1'b1);

  assign mem_ready = pending_q && (wait_count_q == '0);
  assign mem_rdata = rdata_q;

  always_ff @(posedge clock) begin
    if (load_valid) begin
      mem_array[load_index] <= load_data;
    end
    if (accept) begin
      rdata_q <= mem_array[req_index];
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      pending_q <= 1'b0;
      wait_count_q <= '0;
      line_valid_q <= 1'b0;
      line_index_q <= '0;
    end else begin
      if (mem_ready) begin
        pending_q <= 1'b0;
      end else if (pending_q) begin
        wait_count_q <= wait_count_q - 1'b1;
      end
      if (accept) begin
        pending_q <= 1'b1;
        wait_count_q <= line_hit ? '0 : miss_w'(`ITIM_MISS_CYCLES);
        line_valid_q <= 1'b1;
        line_index_q <= req_index;
      end
      // New program contents make the buffered line stale
      if (load_valid) begin
        line_valid_q <= 1'b0;
      end
    end
  end

  // The fetch stage keeps the address steady until the response is back
  assert property (@(posedge clock) disable iff (!reset) pending_q |-> $stable(mem_addr))
    else $error("mem_addr changed while a request was waiting");

endmodule
